/* tb.f */
rtl/cpu_types_pkg.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/register_file.sv
rtl/pc_unit.sv
rtl/mips_core.sv
verification/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mips_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module mips_core_tb \
	--Mdir obj_dir -o mips_core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/mips_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

/* verification/mips_core_tb.sv */
// testbench top with clock, reset, memory models, store trace, compare tasks, directed tests and timeout
module mips_core_tb;

	// run limit in cycles, well above all programs and resets together
	localparam int CYCLE_LIMIT = 2000;

	logic                 clk;
	logic                 rst_n;
	cpu_types_pkg::word_t imem_data;
	cpu_types_pkg::word_t dmem_rdata;
	cpu_types_pkg::word_t imem_addr;
	cpu_types_pkg::word_t dmem_addr;
	cpu_types_pkg::word_t dmem_wdata;
	logic                 dmem_wen;
	logic                 dmem_ren;
	logic                 halt;

	// word-indexed memories
	cpu_types_pkg::word_t imem [256];
	cpu_types_pkg::word_t dmem [256];
	// stores seen at each rising edge
	cpu_types_pkg::word_t trace_addr [$];
	cpu_types_pkg::word_t trace_data [$];
	int prog_len;
	int cycles;

	mips_core i_mips_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_data  (imem_data),
		.dmem_rdata (dmem_rdata),
		.imem_addr  (imem_addr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wen   (dmem_wen),
		.dmem_ren   (dmem_ren),
		.halt       (halt)
	);

	always #5 clk = ~clk;

	// fetch is driven on the falling edge
	always @(negedge clk) begin
		imem_data <= imem[imem_addr[9:2]];
	end

	// load data answers in the same cycle
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	// store port and trace capture
	always @(posedge clk) begin
		if (dmem_wen) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
			trace_addr.push_back(dmem_addr);
			trace_data.push_back(dmem_wdata);
		end
	end

	// read strobe is high for lw only
	always @(posedge clk) begin
		check_word("dmem_ren", {31'b0, (imem_data[31:26] == cpu_types_pkg::LW)},
			{31'b0, dmem_ren});
	end

	// abort when a program runs away
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, halt was never reached within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	// instruction encoders
	function automatic cpu_types_pkg::word_t enc_r(input cpu_types_pkg::funct_t f,
		input cpu_types_pkg::reg_addr_t rs, input cpu_types_pkg::reg_addr_t rt,
		input cpu_types_pkg::reg_addr_t rd);
		return {6'h00, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic cpu_types_pkg::word_t enc_i(input cpu_types_pkg::opcode_t op,
		input cpu_types_pkg::reg_addr_t rs, input cpu_types_pkg::reg_addr_t rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic cpu_types_pkg::word_t enc_j(input cpu_types_pkg::opcode_t op,
		input logic [25:0] target);
		return {op, target};
	endfunction

	// sign extension of a 16 bit immediate
	function automatic cpu_types_pkg::word_t sext(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic check_word(input string name, input cpu_types_pkg::word_t exp,
		input cpu_types_pkg::word_t act);
		if (act !== exp) begin
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_addr(input string name, input cpu_types_pkg::word_t exp,
		input cpu_types_pkg::word_t act);
		if (act !== exp) begin
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	// store trace must hold exactly n entries
	task automatic check_trace_len(input int n);
		if (trace_addr.size() != n) begin
			$display("store trace holds %0d stores at time %0t but %0d were expected",
				trace_addr.size(), $time, n);
			$display("TESTBENCH FAILED");
			$fatal(1, "store count");
		end
	endtask

	task automatic check_store(input int idx, input cpu_types_pkg::word_t addr,
		input cpu_types_pkg::word_t data);
		check_addr($sformatf("store[%0d] addr", idx), addr, trace_addr[idx]);
		check_word($sformatf("store[%0d] data", idx), data, trace_data[idx]);
	endtask

	task automatic check_mem(input cpu_types_pkg::word_t addr, input cpu_types_pkg::word_t exp);
		check_word($sformatf("dmem[%h]", addr), exp, dmem[addr[9:2]]);
	endtask

	// fresh memories where runaway fetches hit a halt
	task automatic new_program();
		prog_len = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'(i));
			dmem[i] = {8'hd0, 8'(i), 8'(~i), 8'(i)};
		end
	endtask

	task automatic emit(input cpu_types_pkg::word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	// lui then ori
	task automatic load_imm(input cpu_types_pkg::reg_addr_t r, input cpu_types_pkg::word_t v);
		emit(enc_i(cpu_types_pkg::LUI, 5'd0, r, v[31:16]));
		emit(enc_i(cpu_types_pkg::ORI, r, r, v[15:0]));
	endtask

	task automatic store(input cpu_types_pkg::reg_addr_t r, input logic [15:0] addr);
		emit(enc_i(cpu_types_pkg::SW, 5'd0, r, addr));
	endtask

	// reset for 3 cycles and run until halt is seen
	task automatic run_program();
		trace_addr.delete();
		trace_data.delete();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		do @(posedge clk); while (!halt);
	endtask

	task automatic test_rtype();
		cpu_types_pkg::funct_t fns [12];
		cpu_types_pkg::word_t exp [12];
		cpu_types_pkg::word_t a;
		cpu_types_pkg::word_t b;
		cpu_types_pkg::word_t s;
		fns = '{cpu_types_pkg::ADDU, cpu_types_pkg::ADD, cpu_types_pkg::SUBU,
			cpu_types_pkg::SUB, cpu_types_pkg::AND, cpu_types_pkg::OR, cpu_types_pkg::XOR,
			cpu_types_pkg::NOR, cpu_types_pkg::SLT, cpu_types_pkg::SLTU,
			cpu_types_pkg::SLLV, cpu_types_pkg::SRLV};
		a = $urandom;
		b = $urandom;
		s = $urandom % 32;
		exp = '{a + b, a + b, a - b, a - b, a & b, a | b, a ^ b, ~(a | b),
			($signed(a) < $signed(b)) ? 32'd1 : 32'd0, (a < b) ? 32'd1 : 32'd0,
			b << s[4:0], b >> s[4:0]};
		new_program();
		load_imm(5'd1, a);
		load_imm(5'd2, b);
		load_imm(5'd3, s);
		for (int k = 0; k < 12; k++) begin
			// variable shifts take the amount from rs
			if (k >= 10)
				emit(enc_r(fns[k], 5'd3, 5'd2, 5'(10 + k)));
			else
				emit(enc_r(fns[k], 5'd1, 5'd2, 5'(10 + k)));
			store(5'(10 + k), 16'(256 + 4 * k));
		end
		emit(enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0));
		run_program();
		for (int k = 0; k < 12; k++)
			check_mem(32'(256 + 4 * k), exp[k]);
	endtask

	task automatic test_immediates();
		cpu_types_pkg::word_t a;
		cpu_types_pkg::word_t n;
		cpu_types_pkg::word_t exp [7];
		a = $urandom;
		// n lies above the sign-extended immediate and below the zero-extended one
		n = 32'hffff_fffe;
		exp = '{a + sext(16'hfff0), ($signed(a) < $signed(sext(16'hfffb))) ? 32'd1 : 32'd0,
			($signed(n) < $signed(sext(16'hfffb))) ? 32'd1 : 32'd0,
			a & 32'h0000_8f0f, a | 32'h0000_f0f0, a ^ 32'h0000_ffff, 32'h9abc_0000};
		new_program();
		load_imm(5'd1, a);
		load_imm(5'd2, n);
		emit(enc_i(cpu_types_pkg::ADDI, 5'd1, 5'd4, 16'hfff0));
		emit(enc_i(cpu_types_pkg::SLTI, 5'd1, 5'd5, 16'hfffb));
		emit(enc_i(cpu_types_pkg::SLTI, 5'd2, 5'd6, 16'hfffb));
		emit(enc_i(cpu_types_pkg::ANDI, 5'd1, 5'd7, 16'h8f0f));
		emit(enc_i(cpu_types_pkg::ORI, 5'd1, 5'd8, 16'hf0f0));
		emit(enc_i(cpu_types_pkg::XORI, 5'd1, 5'd9, 16'hffff));
		emit(enc_i(cpu_types_pkg::LUI, 5'd0, 5'd10, 16'h9abc));
		for (int k = 0; k < 7; k++)
			store(5'(4 + k), 16'(320 + 4 * k));
		emit(enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0));
		run_program();
		for (int k = 0; k < 7; k++)
			check_mem(32'(320 + 4 * k), exp[k]);
	endtask

	task automatic test_memory();
		cpu_types_pkg::word_t v;
		v = $urandom;
		new_program();
		dmem[32] = v;
		emit(enc_i(cpu_types_pkg::LW, 5'd0, 5'd5, 16'h0080));
		store(5'd5, 16'h0084);
		// r0 ignores both an alu write and a load
		emit(enc_i(cpu_types_pkg::ADDIU, 5'd0, 5'd0, 16'd123));
		store(5'd0, 16'h0088);
		emit(enc_i(cpu_types_pkg::LW, 5'd0, 5'd0, 16'h0080));
		store(5'd0, 16'h008c);
		emit(enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0));
		run_program();
		check_mem(32'h84, v);
		check_mem(32'h88, 32'h0);
		check_mem(32'h8c, 32'h0);
	endtask

	task automatic test_branches();
		new_program();
		emit(enc_i(cpu_types_pkg::ADDIU, 5'd0, 5'd1, 16'd5));
		emit(enc_i(cpu_types_pkg::ADDIU, 5'd0, 5'd2, 16'd5));
		emit(enc_i(cpu_types_pkg::ADDIU, 5'd0, 5'd3, 16'd7));
		// beq taken skips a marker
		emit(enc_i(cpu_types_pkg::BEQ, 5'd1, 5'd2, 16'd1));
		store(5'd3, 16'h0200);
		// beq not taken
		emit(enc_i(cpu_types_pkg::BEQ, 5'd1, 5'd3, 16'd1));
		store(5'd1, 16'h0204);
		// bne taken skips a marker
		emit(enc_i(cpu_types_pkg::BNE, 5'd1, 5'd3, 16'd1));
		store(5'd3, 16'h0208);
		// bne not taken
		emit(enc_i(cpu_types_pkg::BNE, 5'd1, 5'd2, 16'd1));
		store(5'd2, 16'h020c);
		emit(enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0));
		run_program();
		check_trace_len(2);
		check_store(0, 32'h204, 32'd5);
		check_store(1, 32'h20c, 32'd5);
	endtask

	task automatic test_jumps();
		cpu_types_pkg::word_t link;
		// jal sits at word 3 so the link is the next word
		link = 32'((3 + 1) * 4);
		new_program();
		emit(enc_j(cpu_types_pkg::J, 26'd3));
		store(5'd0, 16'h0300);
		store(5'd0, 16'h0304);
		emit(enc_j(cpu_types_pkg::JAL, 26'd6));
		store(5'd31, 16'h0308);
		emit(enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0));
		// subroutine at word 6
		store(5'd31, 16'h030c);
		emit(enc_r(cpu_types_pkg::JR, 5'd31, 5'd0, 5'd0));
		run_program();
		check_trace_len(2);
		check_store(0, 32'h30c, link);
		check_store(1, 32'h308, link);
		check_addr("imem_addr at halt", 32'd20, imem_addr);
	endtask

	task automatic test_halt();
		cpu_types_pkg::word_t held;
		new_program();
		emit(enc_i(cpu_types_pkg::ADDIU, 5'd0, 5'd1, 16'd9));
		store(5'd1, 16'h0040);
		emit(enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0));
		store(5'd1, 16'h0044);
		run_program();
		held = imem_addr;
		check_addr("imem_addr at halt", 32'd8, held);
		repeat (5) begin
			@(posedge clk);
			check_addr("imem_addr", held, imem_addr);
			check_word("halt", 32'd1, {31'b0, halt});
		end
		check_trace_len(1);
		check_store(0, 32'h40, 32'd9);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		imem_data = '0;
		cycles = 0;
		prog_len = 0;
		void'($urandom(32'hbff1_1e3e));
		test_rtype();
		test_immediates();
		test_memory();
		test_branches();
		test_jumps();
		test_halt();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* rtl/mips_core.sv */
// mips_core, single-cycle top with control unit, alu, register file, pc unit and datapath muxes
module mips_core (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_types_pkg::word_t imem_data,
	input  cpu_types_pkg::word_t dmem_rdata,
	output cpu_types_pkg::word_t imem_addr,
	output cpu_types_pkg::word_t dmem_addr,
	output cpu_types_pkg::word_t dmem_wdata,
	output logic                 dmem_wen,
	output logic                 dmem_ren,
	output logic                 halt
);

	// fetched word in its three layouts
	cpu_types_pkg::instr_u instr;

	// control outputs
	logic                     reg_wen;
	logic                     cu_dmem_wen;
	logic                     extend_sign;
	logic                     cu_halt;
	logic                     zero;
	cpu_types_pkg::reg_dest_t reg_dest;
	cpu_types_pkg::alu_src_t  alu_src;
	cpu_types_pkg::alu_op_t   alu_op;
	cpu_types_pkg::wb_src_t   wb_src;
	cpu_types_pkg::pc_src_t   pc_src;

	// datapath
	cpu_types_pkg::word_t     pc_plus4;
	cpu_types_pkg::word_t     imm_ext;
	cpu_types_pkg::word_t     rdata1;
	cpu_types_pkg::word_t     rdata2;
	cpu_types_pkg::word_t     alu_b;
	cpu_types_pkg::word_t     alu_result;
	cpu_types_pkg::word_t     wdata;
	cpu_types_pkg::reg_addr_t waddr;
	logic                     halted;
	logic                     rf_wen;

	assign instr = imem_data;

	control_unit i_control_unit (
		.instr       (instr),
		.zero        (zero),
		.reg_wen     (reg_wen),
		.dmem_wen    (cu_dmem_wen),
		.dmem_ren    (dmem_ren),
		.extend_sign (extend_sign),
		.halt        (cu_halt),
		.reg_dest    (reg_dest),
		.alu_src     (alu_src),
		.alu_op      (alu_op),
		.wb_src      (wb_src),
		.pc_src      (pc_src)
	);

	// sign or zero extension of imm16
	assign imm_ext = extend_sign ? {{16{instr.i_fields.imm16[15]}}, instr.i_fields.imm16} :
		{16'h0000, instr.i_fields.imm16};

	// destination register
	always_comb begin
		case (reg_dest)
			cpu_types_pkg::SEL_RT: waddr = instr.i_fields.rt;
			cpu_types_pkg::SEL_RA: waddr = cpu_types_pkg::RA_REG;
			default:               waddr = instr.r_fields.rd;
		endcase
	end

	// write-back source
	always_comb begin
		case (wb_src)
			cpu_types_pkg::SEL_DLOAD: wdata = dmem_rdata;
			cpu_types_pkg::SEL_NPC:   wdata = pc_plus4;
			default:                  wdata = alu_result;
		endcase
	end

	// no state changes while in reset or after halt
	assign rf_wen   = reg_wen && !halted && rst_n;
	assign dmem_wen = cu_dmem_wen && !halted && rst_n;

	register_file i_register_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.wen    (rf_wen),
		.raddr1 (instr.r_fields.rs),
		.raddr2 (instr.r_fields.rt),
		.waddr  (waddr),
		.wdata  (wdata),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	// immediate or rt as second operand
	assign alu_b = (alu_src == cpu_types_pkg::SEL_IMM) ? imm_ext : rdata2;

	alu i_alu (
		.a         (rdata1),
		.b         (alu_b),
		.shamt_src (rdata1[4:0]),
		.op        (alu_op),
		.result    (alu_result),
		.zero      (zero)
	);

	pc_unit i_pc_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.halt      (cu_halt),
		.pc_src    (pc_src),
		.imm_ext   (imm_ext),
		.jr_target (rdata1),
		.addr26    (instr.j_fields.addr26),
		.pc        (imem_addr),
		.pc_plus4  (pc_plus4),
		.halted    (halted)
	);

	// data memory side
	assign dmem_addr  = alu_result;
	assign dmem_wdata = rdata2;
	// high from the halt fetch until reset
	assign halt = cu_halt || halted;

endmodule

/* rtl/pc_unit.sv */
// pc_unit, program counter register, halted flag and next-pc selection
module pc_unit (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   halt,
	input  cpu_types_pkg::pc_src_t pc_src,
	input  cpu_types_pkg::word_t   imm_ext,
	input  cpu_types_pkg::word_t   jr_target,
	input  logic [25:0]            addr26,
	output cpu_types_pkg::word_t   pc,
	output cpu_types_pkg::word_t   pc_plus4,
	output logic                   halted
);

	cpu_types_pkg::word_t next_pc;

	// sequential address, also the link value
	assign pc_plus4 = pc + cpu_types_pkg::PC_INC;

	// next pc mux
	always_comb begin
		case (pc_src)
			// word offset relative to pc+4
			cpu_types_pkg::SEL_BRANCH: next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
			// region bits from pc+4, target in words
			cpu_types_pkg::SEL_JUMP:   next_pc = {pc_plus4[31:28], addr26, 2'b00};
			cpu_types_pkg::SEL_JR:     next_pc = jr_target;
			default:                   next_pc = pc_plus4;
		endcase
	end

	// pc register and halted flag
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc     <= cpu_types_pkg::RESET_PC;
			halted <= 1'b0;
		end else begin
			// halt is sticky until reset
			if (halt)
				halted <= 1'b1;
			// pc freezes on the halt instruction itself
			if (!halt && !halted)
				pc <= next_pc;
		end
	end

endmodule

/* rtl/register_file.sv */
// register_file, 32 x 32 bit registers, two asynchronous reads, one edge write, r0 at zero
module register_file (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     wen,
	input  cpu_types_pkg::reg_addr_t raddr1,
	input  cpu_types_pkg::reg_addr_t raddr2,
	input  cpu_types_pkg::reg_addr_t waddr,
	input  cpu_types_pkg::word_t     wdata,
	output cpu_types_pkg::word_t     rdata1,
	output cpu_types_pkg::word_t     rdata2
);

	// register array
	cpu_types_pkg::word_t regs [cpu_types_pkg::REG_COUNT];

	// write port
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// every register starts at zero
			for (int i = 0; i < cpu_types_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			// writes to r0 are dropped so it stays zero
			regs[waddr] <= wdata;
		end
	end

	// read ports, no bypass in a single-cycle core
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

/* rtl/alu.sv */
// alu, add, subtract, logic, variable shifts, set-less-than, lui placement and zero flag
module alu (
	input  cpu_types_pkg::word_t   a,
	input  cpu_types_pkg::word_t   b,
	input  logic [4:0]             shamt_src,
	input  cpu_types_pkg::alu_op_t op,
	output cpu_types_pkg::word_t   result,
	output logic                   zero
);

	// operation select
	always_comb begin
		result = '0;
		case (op)
			// no overflow trap, add and addu are the same
			cpu_types_pkg::ALU_ADD:  result = a + b;
			cpu_types_pkg::ALU_SUB:  result = a - b;
			cpu_types_pkg::ALU_AND:  result = a & b;
			cpu_types_pkg::ALU_OR:   result = a | b;
			cpu_types_pkg::ALU_XOR:  result = a ^ b;
			cpu_types_pkg::ALU_NOR:  result = ~(a | b);
			// signed compare, one or zero
			cpu_types_pkg::ALU_SLT: begin
				result = {31'b0, ($signed(a) < $signed(b))};
			end
			// unsigned compare
			cpu_types_pkg::ALU_SLTU: begin
				result = {31'b0, (a < b)};
			end
			// sllv and srlv shift b by rs[4:0]
			cpu_types_pkg::ALU_SLL:  result = b << shamt_src;
			cpu_types_pkg::ALU_SRL:  result = b >> shamt_src;
			// immediate goes to the upper half
			cpu_types_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
			default:                 result = '0;
		endcase
	end

	// branch compare flag
	assign zero = (result == '0);

endmodule

/* rtl/control_unit.sv */
// control_unit, decodes an instruction word into enables, mux selects, alu op and halt
module control_unit (
	input  cpu_types_pkg::instr_u    instr,
	input  logic                     zero,
	output logic                     reg_wen,
	output logic                     dmem_wen,
	output logic                     dmem_ren,
	output logic                     extend_sign,
	output logic                     halt,
	output cpu_types_pkg::reg_dest_t reg_dest,
	output cpu_types_pkg::alu_src_t  alu_src,
	output cpu_types_pkg::alu_op_t   alu_op,
	output cpu_types_pkg::wb_src_t   wb_src,
	output cpu_types_pkg::pc_src_t   pc_src
);

	// instruction class
	logic is_rtype;
	logic is_jtype;
	logic is_jr;

	// opcode zero means function field decides
	assign is_rtype = (instr.r_fields.opcode == cpu_types_pkg::RTYPE);
	// j and jal carry a 26 bit target
	assign is_jtype = (instr.j_fields.opcode == cpu_types_pkg::J) ||
		(instr.j_fields.opcode == cpu_types_pkg::JAL);
	assign is_jr = is_rtype && (instr.r_fields.funct == cpu_types_pkg::JR);

	// main decode
	always_comb begin
		// defaults give a no-op
		reg_wen     = 1'b0;
		dmem_wen    = 1'b0;
		dmem_ren    = 1'b0;
		extend_sign = 1'b1;
		halt        = 1'b0;
		reg_dest    = cpu_types_pkg::SEL_RD;
		alu_src     = cpu_types_pkg::SEL_REG_DATA;
		alu_op      = cpu_types_pkg::ALU_ADD;
		wb_src      = cpu_types_pkg::SEL_RESULT;

		if (is_rtype) begin
			// r group, alu op from funct, result into rd
			reg_wen = 1'b1;
			case (instr.r_fields.funct)
				cpu_types_pkg::SLLV: alu_op = cpu_types_pkg::ALU_SLL;
				cpu_types_pkg::SRLV: alu_op = cpu_types_pkg::ALU_SRL;
				cpu_types_pkg::ADD:  alu_op = cpu_types_pkg::ALU_ADD;
				cpu_types_pkg::ADDU: alu_op = cpu_types_pkg::ALU_ADD;
				cpu_types_pkg::SUB:  alu_op = cpu_types_pkg::ALU_SUB;
				cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
				cpu_types_pkg::AND:  alu_op = cpu_types_pkg::ALU_AND;
				cpu_types_pkg::OR:   alu_op = cpu_types_pkg::ALU_OR;
				cpu_types_pkg::XOR:  alu_op = cpu_types_pkg::ALU_XOR;
				cpu_types_pkg::NOR:  alu_op = cpu_types_pkg::ALU_NOR;
				cpu_types_pkg::SLT:  alu_op = cpu_types_pkg::ALU_SLT;
				cpu_types_pkg::SLTU: alu_op = cpu_types_pkg::ALU_SLTU;
				// jr and unknown funct write nothing
				default: reg_wen = 1'b0;
			endcase
		end else begin
			// i and j groups, alu op from opcode
			case (instr.i_fields.opcode)
				cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU: begin
					reg_wen  = 1'b1;
					reg_dest = cpu_types_pkg::SEL_RT;
					alu_src  = cpu_types_pkg::SEL_IMM;
				end
				cpu_types_pkg::SLTI, cpu_types_pkg::SLTIU: begin
					reg_wen  = 1'b1;
					reg_dest = cpu_types_pkg::SEL_RT;
					alu_src  = cpu_types_pkg::SEL_IMM;
					alu_op   = (instr.i_fields.opcode == cpu_types_pkg::SLTI) ?
						cpu_types_pkg::ALU_SLT : cpu_types_pkg::ALU_SLTU;
				end
				// logical immediates zero-extend
				cpu_types_pkg::ANDI, cpu_types_pkg::ORI, cpu_types_pkg::XORI: begin
					reg_wen     = 1'b1;
					reg_dest    = cpu_types_pkg::SEL_RT;
					alu_src     = cpu_types_pkg::SEL_IMM;
					extend_sign = 1'b0;
					case (instr.i_fields.opcode)
						cpu_types_pkg::ANDI: alu_op = cpu_types_pkg::ALU_AND;
						cpu_types_pkg::ORI:  alu_op = cpu_types_pkg::ALU_OR;
						default:             alu_op = cpu_types_pkg::ALU_XOR;
					endcase
				end
				cpu_types_pkg::LUI: begin
					reg_wen     = 1'b1;
					reg_dest    = cpu_types_pkg::SEL_RT;
					alu_src     = cpu_types_pkg::SEL_IMM;
					extend_sign = 1'b0;
					alu_op      = cpu_types_pkg::ALU_LUI;
				end
				// address is rs plus signed offset
				cpu_types_pkg::LW: begin
					reg_wen  = 1'b1;
					dmem_ren = 1'b1;
					reg_dest = cpu_types_pkg::SEL_RT;
					alu_src  = cpu_types_pkg::SEL_IMM;
					wb_src   = cpu_types_pkg::SEL_DLOAD;
				end
				cpu_types_pkg::SW: begin
					dmem_wen = 1'b1;
					alu_src  = cpu_types_pkg::SEL_IMM;
				end
				// compare by subtraction, zero flag decides
				cpu_types_pkg::BEQ, cpu_types_pkg::BNE: alu_op = cpu_types_pkg::ALU_SUB;
				// link address is pc+4 into r31
				cpu_types_pkg::JAL: begin
					reg_wen  = 1'b1;
					reg_dest = cpu_types_pkg::SEL_RA;
					wb_src   = cpu_types_pkg::SEL_NPC;
				end
				cpu_types_pkg::HALT: halt = 1'b1;
				// j and unknown opcodes keep the defaults
				default: ;
			endcase
		end
	end

	// next pc select
	always_comb begin
		pc_src = cpu_types_pkg::SEL_NEXT;
		if ((instr.i_fields.opcode == cpu_types_pkg::BEQ) && zero)
			pc_src = cpu_types_pkg::SEL_BRANCH;
		else if ((instr.i_fields.opcode == cpu_types_pkg::BNE) && !zero)
			pc_src = cpu_types_pkg::SEL_BRANCH;
		else if (is_jtype)
			pc_src = cpu_types_pkg::SEL_JUMP;
		else if (is_jr)
			pc_src = cpu_types_pkg::SEL_JR;
	end

endmodule

/* rtl/cpu_types_pkg.sv */
// word and index types, opcodes, function codes, alu operations, mux selects, instruction union
package cpu_types_pkg;

	// data word or byte address
	typedef logic [31:0] word_t;
	// register index
	typedef logic [4:0] reg_addr_t;

	// first fetch address after reset
	localparam word_t RESET_PC = 32'h0000_0000;
	// link register for jal
	localparam reg_addr_t RA_REG = 5'd31;
	// number of architectural registers
	localparam int REG_COUNT = 32;
	// sequential step, one word
	localparam word_t PC_INC = 32'd4;

	// supported opcodes, zero selects the r group
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		ADDIU = 6'h09,
		SLTI  = 6'h0a,
		SLTIU = 6'h0b,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		XORI  = 6'h0e,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// r-type function field
	typedef enum logic [5:0] {
		SLLV = 6'h04,
		SRLV = 6'h06,
		JR   = 6'h08,
		ADD  = 6'h20,
		ADDU = 6'h21,
		SUB  = 6'h22,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2a,
		SLTU = 6'h2b
	} funct_t;

	// alu operation select
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		ALU_LUI  = 4'd10
	} alu_op_t;

	// next pc source
	typedef enum logic [1:0] {
		SEL_NEXT   = 2'd0,
		SEL_BRANCH = 2'd1,
		SEL_JUMP   = 2'd2,
		SEL_JR     = 2'd3
	} pc_src_t;

	// register write-back source
	typedef enum logic [1:0] {
		SEL_RESULT = 2'd0,
		SEL_DLOAD  = 2'd1,
		SEL_NPC    = 2'd2
	} wb_src_t;

	// second alu operand source
	typedef enum logic {
		SEL_REG_DATA = 1'b0,
		SEL_IMM      = 1'b1
	} alu_src_t;

	// destination register select, ra means register 31
	typedef enum logic [1:0] {
		SEL_RD = 2'd0,
		SEL_RT = 2'd1,
		SEL_RA = 2'd2
	} reg_dest_t;

	// r layout
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		funct_t    funct;
	} r_fields_t;

	// i layout
	typedef struct packed {
		opcode_t    opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		logic [15:0] imm16;
	} i_fields_t;

	// j layout
	typedef struct packed {
		opcode_t     opcode;
		logic [25:0] addr26;
	} j_fields_t;

	// one instruction word, three views
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
		j_fields_t j_fields;
	} instr_u;

endpackage
